/* ebox_defines.svh */
`ifndef EBOX_DEFINES_SVH
`define EBOX_DEFINES_SVH

// Machine word, bits numbered 0 (MSB) to 35
`define EBOX_WORD_WIDTH 36

// Control RAM addressing
`define EBOX_CRAM_ADR_WIDTH 8

// Immediate constant carried in each microword
`define EBOX_MAGIC_WIDTH 9

// Words in flight between sequencer and data path
`define EBOX_QUEUE_DEPTH 4

`endif

/* eboxPkg.sv */
`include "ebox_defines.svh"

package eboxPkg;

  typedef logic [0:`EBOX_WORD_WIDTH-1] ebusWord_t;      // Bit 0 is the MSB
  typedef logic [0:`EBOX_CRAM_ADR_WIDTH-1] cramAdr_t;

  typedef enum logic [2:0] {
    AD_A   = 3'd0,                                      // AR
    AD_B   = 3'd1,                                      // BR
    AD_ADD = 3'd2,                                      // AR + BR
    AD_SUB = 3'd3,                                      // AR - BR
    AD_AND = 3'd4,
    AD_OR  = 3'd5,
    AD_XOR = 3'd6,
    AD_INC = 3'd7                                       // AR + 1
  } adFunc_t;

  typedef enum logic [1:0] {
    AR_HOLD  = 2'd0,
    AR_AD    = 2'd1,                                    // Adder result
    AR_EBUS  = 2'd2,                                    // Bus input
    AR_MAGIC = 2'd3                                     // Magic field, zero-extended
  } arSel_t;

  // One control RAM word, 25 bits
  typedef struct packed {
    cramAdr_t                       j;                  // Next microaddress
    adFunc_t                        ad;
    arSel_t                         arSel;
    logic                           brLoad;             // BR gets old AR
    logic                           ebusDrive;          // Put new AR on bus
    logic [0:`EBOX_MAGIC_WIDTH-1]   magic;
    logic                           halt;
  } microWord_t;

endpackage

/* microQueueIf.sv */
`timescale 1ns/1ps

// Control words and credits between sequencer, queue and data path
interface microQueueIf #(
  parameter type payload_t = logic
) ();

  logic     push;                                       // Sequencer writes word
  payload_t word;
  logic     headValid;                                  // Queue not empty
  payload_t headWord;                                   // Oldest entry
  logic     take;                                       // Data path consumes head
  logic     credit;                                     // One slot freed

  modport sequencer (
    output push, word,
    input  credit
  );

  modport queueIn (
    input push, word
  );

  modport queueOut (
    output headValid, headWord,
    input  take
  );

  modport executor (
    input  headValid, headWord,
    output take, credit
  );

endinterface

/* microSequencer.sv */
`timescale 1ns/1ps
`include "ebox_defines.svh"

module microSequencer (
  input  logic               eboxClk,
  input  logic               reset,
  input  logic               cramWrite,
  input  eboxPkg::cramAdr_t  cramAdr,
  input  eboxPkg::microWord_t cramData,
  input  logic               start,
  input  eboxPkg::cramAdr_t  startAdr,
  microQueueIf.sequencer     q
);

  localparam int creditWidth = $clog2(`EBOX_QUEUE_DEPTH + 1);

  eboxPkg::microWord_t cram [0:(2**`EBOX_CRAM_ADR_WIDTH)-1];

  eboxPkg::cramAdr_t   uAdr;                            // Next read address when idle pipe
  eboxPkg::cramAdr_t   readAdr;
  eboxPkg::microWord_t rdWord;                          // Word read last cycle
  logic                running;
  logic                pending;                         // rdWord waits to be pushed
  logic [creditWidth-1:0] credits;
  logic                creditOk;
  logic                doRead;

  // A pending word already holds one credit in reserve
  assign creditOk = pending ? (credits > creditWidth'(1)) : (credits != '0);

  // Chase the jump field straight from the word just read
  assign readAdr = pending ? rdWord.j : uAdr;

  assign doRead = running && creditOk && !(pending && rdWord.halt);

  assign q.push = pending;
  assign q.word = rdWord;

  always_ff @(posedge eboxClk) begin
    if (cramWrite) begin
      cram[cramAdr] <= cramData;                        // Loaded only while idle
    end
    if (doRead) begin
      rdWord <= cram[readAdr];
    end
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      running <= 1'b0;
      pending <= 1'b0;
      uAdr    <= '0;
    end else begin
      pending <= doRead;
      if (!running && start) begin
        running <= 1'b1;
        uAdr    <= startAdr;
      end else if (pending) begin
        uAdr <= rdWord.j;
        if (rdWord.halt) begin
          running <= 1'b0;                              // Halt word leaves, back to idle
        end
      end
    end
  end

  // Spend on push, refund on each credit pulse
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      credits <= creditWidth'(`EBOX_QUEUE_DEPTH);
    end else begin
      case ({q.push, q.credit})
        2'b10:   credits <= credits - creditWidth'(1);
        2'b01:   credits <= credits + creditWidth'(1);
        default: credits <= credits;
      endcase
    end
  end

  pushHasCredit: assert property (
    @(posedge eboxClk) disable iff (reset)
    q.push |-> credits != '0
  );

  creditBounded: assert property (
    @(posedge eboxClk) disable iff (reset)
    credits <= creditWidth'(`EBOX_QUEUE_DEPTH)
  );

  writeWhileIdle: assert property (
    @(posedge eboxClk) disable iff (reset)
    cramWrite |-> !running
  );

endmodule

/* microWordQueue.sv */
`timescale 1ns/1ps
`include "ebox_defines.svh"

module microWordQueue #(
  parameter type payload_t = logic
) (
  input  logic          eboxClk,
  input  logic          reset,
  microQueueIf.queueIn  inSide,
  microQueueIf.queueOut outSide
);

  localparam int depth      = `EBOX_QUEUE_DEPTH;
  localparam int ptrWidth   = $clog2(depth);
  localparam int countWidth = $clog2(depth + 1);

  payload_t              mem [0:depth-1];
  logic [ptrWidth-1:0]   wrPtr;
  logic [ptrWidth-1:0]   rdPtr;
  logic [countWidth-1:0] count;

  assign outSide.headValid = count != '0;
  assign outSide.headWord  = mem[rdPtr];                // Oldest entry

  always_ff @(posedge eboxClk) begin
    if (inSide.push) begin
      mem[wrPtr] <= inSide.word;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (inSide.push) begin
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + ptrWidth'(1);
      end
      if (outSide.take) begin
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + ptrWidth'(1);
      end
      case ({inSide.push, outSide.take})
        2'b10:   count <= count + countWidth'(1);
        2'b01:   count <= count - countWidth'(1);
        default: count <= count;                        // Both or neither
      endcase
    end
  end

  // Credits upstream keep this from firing
  noOverflow: assert property (
    @(posedge eboxClk) disable iff (reset)
    inSide.push |-> count != countWidth'(depth)
  );

  noUnderflow: assert property (
    @(posedge eboxClk) disable iff (reset)
    outSide.take |-> count != '0
  );

endmodule

/* dataPath.sv */
`timescale 1ns/1ps

module dataPath (
  input  logic               eboxClk,
  input  logic               reset,
  microQueueIf.executor      q,
  input  eboxPkg::ebusWord_t ebusIn,
  input  logic               ebusHold,
  output eboxPkg::ebusWord_t ebusOut,
  output logic               ebusValid,
  output logic               done
);

  eboxPkg::microWord_t w;
  eboxPkg::ebusWord_t  AR;
  eboxPkg::ebusWord_t  BR;
  eboxPkg::ebusWord_t  AD;                              // Adder/logic result
  eboxPkg::ebusWord_t  arNext;
  logic                stalled;
  logic                execute;

  assign w = q.headWord;

  // Output word still waiting on the bus
  assign stalled = ebusValid && ebusHold;
  assign execute = q.headValid && !stalled;

  assign q.take   = execute;
  assign q.credit = execute;                            // Slot freed same cycle

  always_comb begin
    case (w.ad)
      eboxPkg::AD_A:   AD = AR;
      eboxPkg::AD_B:   AD = BR;
      eboxPkg::AD_ADD: AD = AR + BR;                    // Carry out of bit 0 dropped
      eboxPkg::AD_SUB: AD = AR - BR;
      eboxPkg::AD_AND: AD = AR & BR;
      eboxPkg::AD_OR:  AD = AR | BR;
      eboxPkg::AD_XOR: AD = AR ^ BR;
      eboxPkg::AD_INC: AD = AR + eboxPkg::ebusWord_t'(1);
      default:         AD = AR;
    endcase
  end

  always_comb begin
    case (w.arSel)
      eboxPkg::AR_AD:    arNext = AD;
      eboxPkg::AR_EBUS:  arNext = ebusIn;
      eboxPkg::AR_MAGIC: arNext = eboxPkg::ebusWord_t'(w.magic);
      default:           arNext = AR;                   // AR_HOLD
    endcase
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      AR <= '0;
      BR <= '0;
    end else if (execute) begin
      AR <= arNext;
      if (w.brLoad) begin
        BR <= AR;                                       // Old AR, not arNext
      end
    end
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ebusValid <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= execute && w.halt;
      if (!stalled) begin
        ebusValid <= execute && w.ebusDrive;
      end
    end
  end

  always_ff @(posedge eboxClk) begin
    if (execute && w.ebusDrive) begin
      ebusOut <= arNext;                                // Only reached when not stalled
    end
  end

  holdKeepsOutput: assert property (
    @(posedge eboxClk) disable iff (reset)
    (ebusValid && ebusHold) |=> (ebusValid && $stable(ebusOut))
  );

endmodule

/* ebox.sv */
`timescale 1ns/1ps

module ebox (
  input  logic                eboxClk,
  input  logic                reset,

  input  logic                cramWrite,            // Control RAM load port
  input  eboxPkg::cramAdr_t   cramAdr,
  input  eboxPkg::microWord_t cramData,

  input  logic                start,
  input  eboxPkg::cramAdr_t   startAdr,

  input  eboxPkg::ebusWord_t  ebusIn,
  input  logic                ebusHold,             // Back-pressure from the bus

  output eboxPkg::ebusWord_t  ebusOut,
  output logic                ebusValid,
  output logic                done
);

  microQueueIf #(.payload_t(eboxPkg::microWord_t)) uQueue ();

  microSequencer seq0 (
    .eboxClk  (eboxClk),
    .reset    (reset),
    .cramWrite(cramWrite),
    .cramAdr  (cramAdr),
    .cramData (cramData),
    .start    (start),
    .startAdr (startAdr),
    .q        (uQueue.sequencer)
  );

  microWordQueue #(.payload_t(eboxPkg::microWord_t)) queue0 (
    .eboxClk(eboxClk),
    .reset  (reset),
    .inSide (uQueue.queueIn),
    .outSide(uQueue.queueOut)
  );

  dataPath edp0 (
    .eboxClk  (eboxClk),
    .reset    (reset),
    .q        (uQueue.executor),
    .ebusIn   (ebusIn),
    .ebusHold (ebusHold),
    .ebusOut  (ebusOut),
    .ebusValid(ebusValid),
    .done     (done)
  );

endmodule

/* tbEbox.sv */
`timescale 1ns/1ps
`include "ebox_defines.svh"

module tbEbox;

  localparam int clkPeriod = 100;
  localparam int resetCycles = 5;
  localparam int totalProgWords = 8 * 4 + 2 * 6 + 2 * 9 + 30;   // Words run over all tests
  localparam int watchdogCycles = totalProgWords * 4 + 200;

  logic                eboxClk;
  logic                reset;
  logic                cramWrite;
  eboxPkg::cramAdr_t   cramAdr;
  eboxPkg::microWord_t cramData;
  logic                start;
  eboxPkg::cramAdr_t   startAdr;
  eboxPkg::ebusWord_t  ebusIn;
  logic                ebusHold;
  eboxPkg::ebusWord_t  ebusOut;
  logic                ebusValid;
  logic                done;

  logic [31:0]         dataLfsr;                        // Magic values and bus words
  logic [31:0]         holdLfsr;                        // Hold pattern
  logic                holdEnable;
  eboxPkg::ebusWord_t  gotQ [$];                        // Every word taken off the bus
  int                  doneCount;
  eboxPkg::cramAdr_t   progAdr [$];
  eboxPkg::microWord_t progWord [$];
  eboxPkg::ebusWord_t  expQ [$];
  eboxPkg::ebusWord_t  arModel;
  eboxPkg::ebusWord_t  brModel;
  eboxPkg::ebusWord_t  busValue;                        // ebusIn during a run
  int                  wordErrors;
  int                  countErrors;
  int                  otherErrors;

  ebox i_ebox (
    .eboxClk  (eboxClk),
    .reset    (reset),
    .cramWrite(cramWrite),
    .cramAdr  (cramAdr),
    .cramData (cramData),
    .start    (start),
    .startAdr (startAdr),
    .ebusIn   (ebusIn),
    .ebusHold (ebusHold),
    .ebusOut  (ebusOut),
    .ebusValid(ebusValid),
    .done     (done)
  );

  initial begin
    eboxClk = 1'b0;
    forever #(clkPeriod / 2) eboxClk = ~eboxClk;
  end

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [35:0] randBits(input int n);
    logic [35:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[34:0], dataLfsr[0]};
      dataLfsr = lfsrStep(dataLfsr);                    // One step per bit
    end
    return v;
  endfunction

  function automatic eboxPkg::ebusWord_t adderResult(input eboxPkg::adFunc_t f,
      input eboxPkg::ebusWord_t a, input eboxPkg::ebusWord_t b);
    case (f)
      eboxPkg::AD_A:   return a;
      eboxPkg::AD_B:   return b;
      eboxPkg::AD_ADD: return a + b;                    // Wraps at 36 bits
      eboxPkg::AD_SUB: return a - b;
      eboxPkg::AD_AND: return a & b;
      eboxPkg::AD_OR:  return a | b;
      eboxPkg::AD_XOR: return a ^ b;
      default:         return a + 36'd1;                // AD_INC
    endcase
  endfunction

  task automatic compareWord(input string name, input eboxPkg::ebusWord_t got,
      input eboxPkg::ebusWord_t exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      wordErrors++;
    end
  endtask

  task automatic compareCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      countErrors++;
    end
  endtask

  task automatic clearProgram();
    progAdr.delete();
    progWord.delete();
    expQ.delete();
  endtask

  // Adds one word and steps the AR/BR model in execution order
  task automatic emitWord(input eboxPkg::cramAdr_t adr, input eboxPkg::cramAdr_t next,
      input eboxPkg::adFunc_t ad, input eboxPkg::arSel_t sel, input logic brLoad,
      input logic drive, input logic [8:0] magic, input logic halt);
    eboxPkg::microWord_t w;
    eboxPkg::ebusWord_t  newAr;
    w.j         = next;
    w.ad        = ad;
    w.arSel     = sel;
    w.brLoad    = brLoad;
    w.ebusDrive = drive;
    w.magic     = magic;
    w.halt      = halt;
    progAdr.push_back(adr);
    progWord.push_back(w);
    case (sel)
      eboxPkg::AR_AD:    newAr = adderResult(ad, arModel, brModel);
      eboxPkg::AR_EBUS:  newAr = busValue;
      eboxPkg::AR_MAGIC: newAr = {27'd0, magic};
      default:           newAr = arModel;
    endcase
    if (brLoad) begin
      brModel = arModel;
    end
    arModel = newAr;
    if (drive) begin
      expQ.push_back(newAr);
    end
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progAdr.size(); i++) begin
      @(negedge eboxClk);
      cramWrite = 1'b1;
      cramAdr   = progAdr[i];
      cramData  = progWord[i];
    end
    @(negedge eboxClk);
    cramWrite = 1'b0;
  endtask

  task automatic runProgram(input eboxPkg::cramAdr_t startAt, input logic holdOn,
      output int firstOut);
    int doneBase;
    int waited;
    int limit;
    limit    = progWord.size() * 4 + 50;
    firstOut = gotQ.size();
    doneBase = doneCount;
    @(posedge eboxClk);
    holdEnable = holdOn;
    @(negedge eboxClk);
    ebusIn   = busValue;
    start    = 1'b1;
    startAdr = startAt;
    @(negedge eboxClk);
    start  = 1'b0;
    waited = 0;
    while (doneCount == doneBase && waited < limit) begin
      @(posedge eboxClk);
      waited++;
    end
    if (doneCount == doneBase) begin
      $display("done did not pulse within %0d cycles of start at %h", limit, startAt);
      otherErrors++;
    end
    holdEnable = 1'b0;
    repeat (3) @(posedge eboxClk);                      // Last held word leaves once hold drops
    compareCount("done pulses", doneCount - doneBase, 1);
  endtask

  task automatic checkRun(input int first, input string name);
    int got;
    got = gotQ.size() - first;
    compareCount({name, " output count"}, got, expQ.size());
    for (int i = 0; i < got && i < expQ.size(); i++) begin
      compareWord({name, " ebusOut"}, gotQ[first + i], expQ[i]);
    end
  endtask

  task automatic idleQuiet();
    int validSeen;
    int doneSeen;
    validSeen = 0;
    doneSeen  = 0;
    repeat (20) begin
      @(negedge eboxClk);
      if (ebusValid) validSeen++;
      if (done) doneSeen++;
    end
    compareCount("ebusValid cycles while idle", validSeen, 0);
    compareCount("done cycles while idle", doneSeen, 0);
  endtask

  task automatic adderFunctions();
    logic [35:0]         r;
    logic [8:0]          m1;
    logic [8:0]          m2;
    int                  first;
    eboxPkg::cramAdr_t   base;
    eboxPkg::adFunc_t    f;
    for (int k = 0; k < 8; k++) begin
      f    = eboxPkg::adFunc_t'(k);
      base = eboxPkg::cramAdr_t'(k * 4);
      r    = randBits(9);
      m1   = r[8:0];
      r    = randBits(9);
      m2   = r[8:0];
      clearProgram();
      emitWord(base, base + 8'd1, eboxPkg::AD_A, eboxPkg::AR_MAGIC, 1'b0, 1'b0, m1, 1'b0);
      emitWord(base + 8'd1, base + 8'd2, eboxPkg::AD_A, eboxPkg::AR_HOLD, 1'b1, 1'b0, 9'd0,
               1'b0);                                   // BR takes first value
      emitWord(base + 8'd2, base + 8'd3, eboxPkg::AD_A, eboxPkg::AR_MAGIC, 1'b0, 1'b0, m2, 1'b0);
      emitWord(base + 8'd3, base, f, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b1);
      loadProgram();
      runProgram(base, 1'b0, first);
      checkRun(first, $sformatf("adder %s", f.name()));
    end
  endtask

  task automatic busLoadAndJumps();
    int first;
    for (int r = 0; r < 2; r++) begin
      busValue = randBits(36);
      clearProgram();
      emitWord(8'd200, 8'd47, eboxPkg::AD_A, eboxPkg::AR_EBUS, 1'b0, 1'b1, 9'd0, 1'b0);
      emitWord(8'd47, 8'd233, eboxPkg::AD_A, eboxPkg::AR_MAGIC, 1'b1, 1'b1, 9'h15a, 1'b0);
      emitWord(8'd233, 8'd90, eboxPkg::AD_ADD, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
      emitWord(8'd90, 8'd250, eboxPkg::AD_A, eboxPkg::AR_EBUS, 1'b0, 1'b1, 9'd0, 1'b0);
      emitWord(8'd250, 8'd60, eboxPkg::AD_XOR, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
      emitWord(8'd60, 8'd200, eboxPkg::AD_SUB, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b1);
      loadProgram();
      runProgram(8'd200, 1'b0, first);
      checkRun(first, "bus load");
    end
  endtask

  task automatic backPressure();
    int freeFirst;
    int heldFirst;
    clearProgram();
    emitWord(8'd100, 8'd101, eboxPkg::AD_A, eboxPkg::AR_MAGIC, 1'b0, 1'b1, 9'h0f3, 1'b0);
    emitWord(8'd101, 8'd102, eboxPkg::AD_A, eboxPkg::AR_HOLD, 1'b1, 1'b0, 9'd0, 1'b0);
    emitWord(8'd102, 8'd103, eboxPkg::AD_INC, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
    emitWord(8'd103, 8'd104, eboxPkg::AD_ADD, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
    emitWord(8'd104, 8'd105, eboxPkg::AD_XOR, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
    emitWord(8'd105, 8'd106, eboxPkg::AD_A, eboxPkg::AR_MAGIC, 1'b1, 1'b1, 9'h1c4, 1'b0);
    emitWord(8'd106, 8'd107, eboxPkg::AD_SUB, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
    emitWord(8'd107, 8'd108, eboxPkg::AD_OR, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b0);
    emitWord(8'd108, 8'd100, eboxPkg::AD_AND, eboxPkg::AR_AD, 1'b0, 1'b1, 9'd0, 1'b1);
    loadProgram();
    runProgram(8'd100, 1'b0, freeFirst);
    checkRun(freeFirst, "free run");
    runProgram(8'd100, 1'b1, heldFirst);                // Same program, random hold
    checkRun(heldFirst, "held run");
  endtask

  task automatic creditFlow();
    logic [35:0]       r;
    eboxPkg::cramAdr_t adr;
    int                first;
    clearProgram();
    for (int i = 0; i < 30; i++) begin
      adr = 8'd140 + eboxPkg::cramAdr_t'(i);
      r   = randBits(9);
      if (i % 5 == 0) begin
        emitWord(adr, adr + 8'd1, eboxPkg::AD_A, eboxPkg::AR_MAGIC, i % 4 == 1, i % 3 != 2,
                 r[8:0], i == 29);
      end else begin
        emitWord(adr, adr + 8'd1, eboxPkg::adFunc_t'(r[2:0]), eboxPkg::AR_AD, i % 4 == 1,
                 i % 3 != 2, 9'd0, i == 29);
      end
    end
    loadProgram();
    runProgram(8'd140, 1'b1, first);
    checkRun(first, "credit run");
  endtask

  // Hold driver and bus monitor share the falling edge
  initial begin
    ebusHold  = 1'b0;
    holdLfsr  = 32'hd868;
    doneCount = 0;
    forever begin
      @(negedge eboxClk);
      if (holdEnable) begin
        ebusHold = holdLfsr[0];
        holdLfsr = lfsrStep(holdLfsr);
      end else begin
        ebusHold = 1'b0;
      end
      if (ebusValid && !ebusHold) begin
        gotQ.push_back(ebusOut);                        // Taken at the next edge
      end
      if (done) begin
        doneCount++;
      end
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge eboxClk);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    cramWrite   = 1'b0;
    cramAdr     = '0;
    cramData    = '0;
    start       = 1'b0;
    startAdr    = '0;
    ebusIn      = '0;
    holdEnable  = 1'b0;
    dataLfsr    = 32'hd868;
    arModel     = '0;
    brModel     = '0;
    busValue    = '0;
    wordErrors  = 0;
    countErrors = 0;
    otherErrors = 0;
    repeat (resetCycles) @(negedge eboxClk);
    reset = 1'b0;

    idleQuiet();
    adderFunctions();
    busLoadAndJumps();
    backPressure();
    creditFlow();

    $display("Errors: %0d word, %0d count, %0d other", wordErrors, countErrors, otherErrors);
    if (wordErrors + countErrors + otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
eboxPkg.sv
microQueueIf.sv
microSequencer.sv
microWordQueue.sv
dataPath.sv
ebox.sv
tbEbox.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbEbox
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FLIST)) ebox_defines.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
